// File: mem_test_seq.sv
`timescale 1ns/1ns

module mem_test_seq #(
  parameter int N_WORDS = 256
) (
  input  logic                          clk_design,
  input  logic                          rst_n,
  input  logic [6:0]                    btns,
  input  logic                          sd_done,
  input  logic [sdram_pkg::DATA_W-1:0]  sd_data_out,
  output sdram_pkg::sdram_addr_t        sd_addr,
  output logic                          sd_rw,
  output logic [sdram_pkg::DATA_W-1:0]  sd_data_in,
  output logic                          sd_in_valid,
  output logic [7:0]                    leds
);

  localparam int AW = sdram_pkg::ADDR_W;
  localparam int DW = sdram_pkg::DATA_W;

  localparam logic [AW-1:0] LAST_IDX = AW'(N_WORDS - 1);

  // test phases
  localparam logic [1:0] P_WRITE = 2'd0;
  localparam logic [1:0] P_READ  = 2'd1;
  localparam logic [1:0] P_DONE  = 2'd2;

  logic [1:0]    phase;
  logic [5:0]    seed;
  // seed from the button press, applied when the restart happens
  logic [5:0]    seed_next;
  logic          restart_req;
  logic          btn0_q;
  logic          btn_rise;
  logic          err;
  logic [6:0]    last_low;
  logic          is_last;
  logic          mismatch;
  logic [AW-1:0] next_idx;

  // test word for index i: i * 0x0101, seed xor'd into the top six bits
  function automatic logic [DW-1:0] pattern(input logic [AW-1:0] idx, input logic [5:0] s);
    return (idx[DW-1:0] * 16'h0101) ^ {s, 10'b0};
  endfunction

  assign btn_rise = btns[0] && !btn0_q;
  assign is_last  = (sd_addr.flat == LAST_IDX);
  assign next_idx = sd_addr.flat + 1'b1;
  assign mismatch = (sd_data_out != pattern(sd_addr.flat, seed));

  // sticky error on top, low bits of the last word read below
  assign leds = {err, last_low};

  always_ff @(posedge clk_design) begin
    if (!rst_n) begin
      phase       <= P_WRITE;
      sd_addr     <= '0;
      sd_rw       <= 1'b0;
      sd_in_valid <= 1'b0;
      seed        <= '0;
      seed_next   <= '0;
      // leaving reset starts a run with seed 0
      restart_req <= 1'b1;
      btn0_q      <= 1'b0;
      err         <= 1'b0;
      last_low    <= '0;
    end else begin
      btn0_q <= btns[0];
      // restart only once no request is left in flight
      if (restart_req && (!sd_in_valid || sd_done)) begin
        restart_req  <= 1'b0;
        phase        <= P_WRITE;
        sd_addr.flat <= '0;
        seed         <= seed_next;
        err          <= 1'b0;
        sd_rw        <= 1'b1;
        sd_in_valid  <= 1'b1;
        sd_data_in   <= pattern('0, seed_next);
      end else if (sd_done) begin
        case (phase)
          P_WRITE: begin
            if (is_last) begin
              // wrap to index 0 and start reading back
              phase        <= P_READ;
              sd_addr.flat <= '0;
              sd_rw        <= 1'b0;
            end else begin
              sd_addr.flat <= next_idx;
              sd_data_in   <= pattern(next_idx, seed);
            end
          end
          P_READ: begin
            err      <= err | mismatch;
            last_low <= sd_data_out[6:0];
            if (is_last) begin
              phase       <= P_DONE;
              sd_in_valid <= 1'b0;
            end else begin
              sd_addr.flat <= next_idx;
            end
          end
          default: begin
            sd_in_valid <= 1'b0;
          end
        endcase
      end
      // a new press overrides the clear above
      if (btn_rise) begin
        restart_req <= 1'b1;
        seed_next   <= btns[6:1];
      end
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_sdram_top -f src.f

# keep going after an assertion error so the testbench can report it
out=$(./obj_dir/Vtb_sdram_top +verilator+error+limit+1000)
echo "$out"

if grep -qx "=== PASS ===" <<< "$out"; then
  exit 0
fi
exit 1

// File: sdram_ctrl.sv
`timescale 1ns/1ns

module sdram_ctrl #(
  parameter int INIT_CYCLES    = 20000,
  parameter int REFRESH_CYCLES = 780
) (
  input  logic                              clk_design,
  input  logic                              rst_n,
  input  sdram_pkg::sdram_addr_t            sd_addr,
  input  logic                              sd_rw,
  input  logic [sdram_pkg::DATA_W-1:0]      sd_data_in,
  input  logic                              sd_in_valid,
  output logic                              sd_done,
  output logic [sdram_pkg::DATA_W-1:0]      sd_data_out,
  output logic                              sdram_cke,
  output logic                              sdram_csn,
  output logic                              sdram_rasn,
  output logic                              sdram_casn,
  output logic                              sdram_wen,
  output logic [sdram_pkg::BA_W-1:0]        sdram_ba,
  output logic [sdram_pkg::ROW_W-1:0]       sdram_a,
  output logic [1:0]                        sdram_dqm,
  inout  wire  [sdram_pkg::DATA_W-1:0]      sdram_d
);

  localparam int ROW_W = sdram_pkg::ROW_W;
  localparam int COL_W = sdram_pkg::COL_W;
  localparam int DW    = sdram_pkg::DATA_W;

  // shared wait counter must hold the power-up wait and every short delay
  localparam int WAIT_W = (INIT_CYCLES > 15) ? $clog2(INIT_CYCLES + 1) : 4;
  localparam int REF_W  = $clog2(REFRESH_CYCLES + 1);

  // a10 selects all banks on precharge, auto-precharge on read/write
  localparam logic [ROW_W-1:0] A_AUTO_PRE = ROW_W'(13'h0400);

  // fsm encoding
  localparam logic [2:0] S_INIT_WAIT = 3'd0;
  localparam logic [2:0] S_INIT_REF  = 3'd1;
  localparam logic [2:0] S_INIT_MODE = 3'd2;
  localparam logic [2:0] S_IDLE      = 3'd3;
  localparam logic [2:0] S_RW        = 3'd4;
  localparam logic [2:0] S_WAIT      = 3'd5;
  localparam logic [2:0] S_DONE      = 3'd6;

  logic [2:0]        state;
  logic [2:0]        next_state;
  logic [WAIT_W-1:0] wait_cnt;
  logic [3:0]        cmd;
  logic              init_ref_second;
  logic              init_done;

  // refresh timer
  logic [REF_W-1:0]  ref_cnt;
  logic              ref_pending;

  // latched request
  logic              req_rw;
  logic [COL_W-1:0]  req_col;
  logic [DW-1:0]     req_data;

  // data bus driver
  logic              dq_oe;
  logic [DW-1:0]     dq_out;

  // one-cycle events that also steer the payload registers
  logic start_pre;
  logic start_mode;
  logic start_ref;
  logic accept;
  logic start_rw;
  logic capture;

  assign start_pre  = (state == S_INIT_WAIT) && (wait_cnt == '0);
  assign start_mode = (state == S_INIT_MODE);
  assign start_ref  = (state == S_IDLE) && ref_pending;
  // the done cycle still sees the old request on valid, skip it
  assign accept     = (state == S_IDLE) && !ref_pending && sd_in_valid && !sd_done;
  assign start_rw   = (state == S_RW);
  assign capture    = (state == S_DONE) && !req_rw;

  // command pins come straight from the command register
  assign {sdram_csn, sdram_rasn, sdram_casn, sdram_wen} = cmd;

  // write mask is not supported, all bytes always enabled
  assign sdram_dqm = 2'b00;

  // tristate data bus, driven only in the write command cycle
  assign sdram_d = dq_oe ? dq_out : {DW{1'bz}};

  // main fsm
  always_ff @(posedge clk_design) begin
    if (!rst_n) begin
      state           <= S_INIT_WAIT;
      next_state      <= S_IDLE;
      wait_cnt        <= WAIT_W'(INIT_CYCLES);
      cmd             <= sdram_pkg::CMD_NOP;
      sdram_cke       <= 1'b0;
      dq_oe           <= 1'b0;
      sd_done         <= 1'b0;
      init_ref_second <= 1'b0;
      init_done       <= 1'b0;
    end else begin
      // defaults, every command lasts one cycle
      cmd     <= sdram_pkg::CMD_NOP;
      dq_oe   <= 1'b0;
      sd_done <= 1'b0;
      case (state)
        S_INIT_WAIT: begin
          // clock enable goes up, then nops for the power-up wait
          sdram_cke <= 1'b1;
          if (start_pre) begin
            cmd        <= sdram_pkg::CMD_PRECHARGE;
            wait_cnt   <= WAIT_W'(sdram_pkg::T_RP - 1);
            next_state <= S_INIT_REF;
            state      <= S_WAIT;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        S_INIT_REF: begin
          // two refresh cycles, then mode register
          cmd             <= sdram_pkg::CMD_REFRESH;
          wait_cnt        <= WAIT_W'(sdram_pkg::T_RFC - 1);
          init_ref_second <= 1'b1;
          next_state      <= init_ref_second ? S_INIT_MODE : S_INIT_REF;
          state           <= S_WAIT;
        end
        S_INIT_MODE: begin
          cmd        <= sdram_pkg::CMD_LOAD_MODE;
          // tMRD of two cycles
          wait_cnt   <= WAIT_W'(1);
          next_state <= S_IDLE;
          state      <= S_WAIT;
        end
        S_IDLE: begin
          init_done <= 1'b1;
          // pending refresh wins over a new request
          if (start_ref) begin
            cmd        <= sdram_pkg::CMD_REFRESH;
            wait_cnt   <= WAIT_W'(sdram_pkg::T_RFC - 1);
            next_state <= S_IDLE;
            state      <= S_WAIT;
          end else if (accept) begin
            cmd        <= sdram_pkg::CMD_ACTIVE;
            // S_WAIT plus S_RW fill the row to column delay
            wait_cnt   <= WAIT_W'(sdram_pkg::T_RCD - 2);
            next_state <= S_RW;
            state      <= S_WAIT;
          end
        end
        S_RW: begin
          // column command with auto-precharge
          cmd   <= req_rw ? sdram_pkg::CMD_WRITE : sdram_pkg::CMD_READ;
          dq_oe <= req_rw;
          // write waits out recovery and precharge
          // read waits for the cas latency
          if (req_rw) begin
            wait_cnt <= WAIT_W'(sdram_pkg::T_WR + sdram_pkg::T_RP - 1);
          end else begin
            wait_cnt <= WAIT_W'(sdram_pkg::CAS_LAT - 1);
          end
          next_state <= S_DONE;
          state      <= S_WAIT;
        end
        S_WAIT: begin
          if (wait_cnt == '0) begin
            state <= next_state;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        S_DONE: begin
          // read data lands in the same edge as done
          sd_done <= 1'b1;
          state   <= S_IDLE;
        end
        default: begin
          state <= S_INIT_WAIT;
        end
      endcase
    end
  end

  // refresh interval timer, starts once init is over
  always_ff @(posedge clk_design) begin
    if (!rst_n) begin
      ref_cnt     <= REF_W'(REFRESH_CYCLES - 1);
      ref_pending <= 1'b0;
    end else begin
      if (start_ref) begin
        ref_pending <= 1'b0;
      end
      // a new tick overrides the clear above
      if (init_done) begin
        if (ref_cnt == '0) begin
          ref_cnt     <= REF_W'(REFRESH_CYCLES - 1);
          ref_pending <= 1'b1;
        end else begin
          ref_cnt <= ref_cnt - 1'b1;
        end
      end
    end
  end

  // address, request and data registers
  always_ff @(posedge clk_design) begin
    if (start_pre) begin
      sdram_a <= A_AUTO_PRE;
    end
    if (start_mode) begin
      sdram_a  <= sdram_pkg::MODE_WORD;
      sdram_ba <= '0;
    end
    if (accept) begin
      // open the row and keep the rest for the column command
      sdram_ba <= sd_addr.fields.ba;
      sdram_a  <= sd_addr.fields.row;
      req_rw   <= sd_rw;
      req_col  <= sd_addr.fields.col;
      req_data <= sd_data_in;
    end
    if (start_rw) begin
      sdram_a <= A_AUTO_PRE | ROW_W'(req_col);
      dq_out  <= req_data;
    end
    if (capture) begin
      sd_data_out <= sdram_d;
    end
  end

endmodule

// File: sdram_pkg.sv
package sdram_pkg;

  // geometry of the 32 MB part, 4 banks of 8192 rows by 512 columns
  localparam int BA_W   = 2;
  localparam int ROW_W  = 13;
  localparam int COL_W  = 9;
  localparam int ADDR_W = BA_W + ROW_W + COL_W;
  localparam int DATA_W = 16;

  // one word address, seen two ways
  // flat is the running word index used by the test sequencer
  // fields is the bank/row/column split used by the controller
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    struct packed {
      logic [BA_W-1:0]  ba;
      logic [ROW_W-1:0] row;
      logic [COL_W-1:0] col;
    } fields;
  } sdram_addr_t;

  // command codes as {cs_n, ras_n, cas_n, we_n}
  localparam logic [3:0] CMD_NOP       = 4'b0111;
  localparam logic [3:0] CMD_ACTIVE    = 4'b0011;
  localparam logic [3:0] CMD_READ      = 4'b0101;
  localparam logic [3:0] CMD_WRITE     = 4'b0100;
  localparam logic [3:0] CMD_REFRESH   = 4'b0001;
  localparam logic [3:0] CMD_PRECHARGE = 4'b0010;
  localparam logic [3:0] CMD_LOAD_MODE = 4'b0000;

  // timing in clk_design cycles
  localparam int CAS_LAT = 2;
  localparam int T_RCD   = 2;
  localparam int T_RP    = 2;
  // refresh to next command
  localparam int T_RFC   = 7;
  // write recovery before auto-precharge starts
  localparam int T_WR    = 2;

  // mode register
  // a9 single write, a6:4 cas latency 2, a3 sequential, a2:0 burst of 1
  localparam logic [ROW_W-1:0] MODE_WORD = {
    3'b000, 1'b1, 2'b00, 3'b010, 1'b0, 3'b000
  };

endpackage

// File: sdram_top.sv
`timescale 1ns/1ns

module sdram_top #(
  parameter int INIT_CYCLES    = 20000,
  parameter int REFRESH_CYCLES = 780,
  parameter int N_WORDS        = 256
) (
  input  logic                              clk_design,
  input  logic                              rst_n,
  input  logic [6:0]                        btns,
  output logic [7:0]                        leds,
  output logic                              sdram_clk,
  output logic                              sdram_cke,
  output logic                              sdram_csn,
  output logic                              sdram_rasn,
  output logic                              sdram_casn,
  output logic                              sdram_wen,
  output logic [sdram_pkg::BA_W-1:0]        sdram_ba,
  output logic [sdram_pkg::ROW_W-1:0]       sdram_a,
  output logic [1:0]                        sdram_dqm,
  inout  wire  [sdram_pkg::DATA_W-1:0]      sdram_d
);

  // request side between sequencer and controller
  sdram_pkg::sdram_addr_t               sd_addr;
  logic                                 sd_rw;
  logic [sdram_pkg::DATA_W-1:0]         sd_data_in;
  logic                                 sd_in_valid;
  logic                                 sd_done;
  logic [sdram_pkg::DATA_W-1:0]         sd_data_out;

  // memory runs on the design clock, no phase shift
  assign sdram_clk = clk_design;

  mem_test_seq #(
    .N_WORDS (N_WORDS)
  ) i_seq (
    .clk_design  (clk_design),
    .rst_n       (rst_n),
    .btns        (btns),
    .sd_done     (sd_done),
    .sd_data_out (sd_data_out),
    .sd_addr     (sd_addr),
    .sd_rw       (sd_rw),
    .sd_data_in  (sd_data_in),
    .sd_in_valid (sd_in_valid),
    .leds        (leds)
  );

  sdram_ctrl #(
    .INIT_CYCLES    (INIT_CYCLES),
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) i_ctrl (
    .clk_design  (clk_design),
    .rst_n       (rst_n),
    .sd_addr     (sd_addr),
    .sd_rw       (sd_rw),
    .sd_data_in  (sd_data_in),
    .sd_in_valid (sd_in_valid),
    .sd_done     (sd_done),
    .sd_data_out (sd_data_out),
    .sdram_cke   (sdram_cke),
    .sdram_csn   (sdram_csn),
    .sdram_rasn  (sdram_rasn),
    .sdram_casn  (sdram_casn),
    .sdram_wen   (sdram_wen),
    .sdram_ba    (sdram_ba),
    .sdram_a     (sdram_a),
    .sdram_dqm   (sdram_dqm),
    .sdram_d     (sdram_d)
  );

endmodule

// File: src.f
sdram_pkg.sv
sdram_ctrl.sv
mem_test_seq.sv
sdram_top.sv
tb_sdram_assert.sv
tb_sdram_model.sv
tb_checker.sv
tb_sdram_top.sv

// File: tb_checker.sv
`timescale 1ns/1ns

module tb_checker #(
  parameter int N_WORDS   = 16,
  parameter int LAST_TEST = 4
) (
  input  logic        clk_design,
  input  logic        rst_n,
  input  logic        csn,
  input  logic        rasn,
  input  logic        casn,
  input  logic        wen,
  input  logic [12:0] a,
  input  logic [1:0]  dqm,
  input  logic [7:0]  leds,
  input  logic        wr_evt,
  input  logic [23:0] wr_flat,
  input  logic [15:0] wr_word,
  input  logic        proto_err,
  input  logic [5:0]  seed,
  input  logic        test_end,
  input  logic [2:0]  test_id,
  input  logic        expect_err,
  output int          pass_count,
  output int          fail_count
);

  logic [3:0]  cmd;
  logic [3:0]  init_cmd [0:3];
  logic [12:0] init_a [0:3];
  int          init_n;
  logic        mode_seen;
  logic        row_open;
  int          n_writes;
  int          n_refresh;
  int          refresh_open;
  int          proto_errs;
  int          dqm_bad;
  logic [15:0] last_word;
  logic [7:0]  exp_leds;
  logic        init_ok;

  assign cmd = {csn, rasn, casn, wen};

  // expected word is index times 0x0101 with the seed in bits 15:10
  function automatic logic [15:0] expected_word(input int i, input logic [5:0] s);
    logic [15:0] v;
    v = 16'(i) * 16'h0101;
    return v ^ {s, 10'b0};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp == act) begin
      pass_count++;
      $display("Pass %s", name);
    end else begin
      fail_count++;
      $display("Fail %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  initial begin
    pass_count = 0;
    fail_count = 0;
    init_n = 0;
    mode_seen = 1'b0;
    row_open = 1'b0;
    n_writes = 0;
    n_refresh = 0;
    refresh_open = 0;
    proto_errs = 0;
    dqm_bad = 0;
  end

  always @(posedge clk_design) begin
    if (rst_n) begin
      // first four non-nop commands after reset
      if (cmd != sdram_pkg::CMD_NOP && init_n < 4) begin
        init_cmd[init_n] = cmd;
        init_a[init_n] = a;
        init_n++;
      end
      if (cmd == sdram_pkg::CMD_LOAD_MODE) mode_seen = 1'b1;
      if (cmd == sdram_pkg::CMD_ACTIVE) row_open = 1'b1;
      if (cmd == sdram_pkg::CMD_READ || cmd == sdram_pkg::CMD_WRITE) row_open = 1'b0;
      if (cmd == sdram_pkg::CMD_REFRESH && mode_seen) begin
        n_refresh++;
        if (row_open) begin
          refresh_open++;
          $display("refresh issued between an ACTIVE and its column command");
        end
      end
      if (proto_err) begin
        proto_errs++;
        $display("memory model saw an illegal command sequence");
      end
      // byte mask stays off
      if (dqm != 2'b00) dqm_bad++;
      // stored word against the reference
      if (wr_evt) begin
        n_writes++;
        if (wr_word != expected_word(int'(wr_flat), seed)) begin
          fail_count++;
          $display("Fail write_%0d expected %0h actual %0h", wr_flat,
                   expected_word(int'(wr_flat), seed), wr_word);
        end
      end
      if (test_end) begin
        if (test_id == 0) begin
          init_ok = init_n == 4 && init_a[0][10] && init_a[3] == sdram_pkg::MODE_WORD;
          check_value("init_order", {sdram_pkg::CMD_PRECHARGE, sdram_pkg::CMD_REFRESH,
                      sdram_pkg::CMD_REFRESH, sdram_pkg::CMD_LOAD_MODE, 16'd1},
                      {init_cmd[0], init_cmd[1], init_cmd[2], init_cmd[3], 15'd0, init_ok});
        end
        check_value($sformatf("run%0d_writes", test_id), N_WORDS, n_writes);
        last_word = expected_word(N_WORDS - 1, seed);
        exp_leds = {expect_err, last_word[6:0]};
        check_value($sformatf("run%0d_leds", test_id), exp_leds, leds);
        n_writes = 0;
        if (test_id == LAST_TEST) begin
          // refresh must have interleaved with the data phases
          check_value("refresh_seen", 1, n_refresh > 0);
          check_value("refresh_open_row", 0, refresh_open);
          check_value("model_protocol", 0, proto_errs);
          check_value("dqm_zero", 0, dqm_bad);
        end
      end
    end
  end

endmodule

// File: tb_sdram_assert.sv
`timescale 1ns/1ns

module tb_sdram_assert (
  input logic       clk_design,
  input logic       rst_n,
  input logic [3:0] cmd,
  input logic       sd_done,
  input logic       dq_oe
);

  // number of failed assertions
  int   fail_cnt = 0;
  // high once the load mode command of the init sequence has gone out
  logic mode_loaded;

  always_ff @(posedge clk_design) begin
    if (!rst_n) begin
      mode_loaded <= 1'b0;
    end else if (cmd == sdram_pkg::CMD_LOAD_MODE) begin
      mode_loaded <= 1'b1;
    end
  end

  // no row or column command until load mode and its wait are over
  a_no_access_in_init: assert property (@(posedge clk_design) disable iff (!rst_n)
    (cmd == sdram_pkg::CMD_ACTIVE || cmd == sdram_pkg::CMD_READ ||
     cmd == sdram_pkg::CMD_WRITE) |->
      mode_loaded && !$past(cmd == sdram_pkg::CMD_LOAD_MODE))
    else begin
      fail_cnt++;
      $error("row or column command issued before init completed");
    end

  // done is a single-cycle pulse
  a_done_pulse: assert property (@(posedge clk_design) disable iff (!rst_n)
    sd_done |=> !sd_done)
    else begin
      fail_cnt++;
      $error("sd_done high two cycles in a row");
    end

  // data bus only driven with the write command
  // and never while data of a recent read can still be on it
  a_dq_in_write: assert property (@(posedge clk_design) disable iff (!rst_n)
    dq_oe |-> cmd == sdram_pkg::CMD_WRITE &&
      !$past(cmd == sdram_pkg::CMD_READ, 1) &&
      !$past(cmd == sdram_pkg::CMD_READ, 2) &&
      !$past(cmd == sdram_pkg::CMD_READ, 3))
    else begin
      fail_cnt++;
      $error("sdram_d driven outside a write command or into read data");
    end

endmodule

bind sdram_ctrl tb_sdram_assert i_assert (
  .clk_design (clk_design),
  .rst_n      (rst_n),
  .cmd        (cmd),
  .sd_done    (sd_done),
  .dq_oe      (dq_oe)
);

// File: tb_sdram_model.sv
`timescale 1ns/1ns

module tb_sdram_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cke,
  input  logic        csn,
  input  logic        rasn,
  input  logic        casn,
  input  logic        wen,
  input  logic [1:0]  ba,
  input  logic [12:0] a,
  inout  wire  [15:0] dq,
  output logic        wr_evt,
  output logic [23:0] wr_flat,
  output logic [15:0] wr_word,
  output logic        proto_err
);

  // small store, index folds bank, low row bits and low column bits
  logic [15:0] mem [0:511];
  logic [3:0]  bank_open;
  logic [12:0] open_row [0:3];
  logic [8:0]  wr_idx;
  logic [8:0]  idx;
  logic [23:0] flat;
  logic [3:0]  cmd;
  logic        rd_pend;
  logic        rd_oe;
  logic [15:0] rd_data;
  // forced high by the testbench to damage word 5 on read
  wire         corrupt = 1'b0;

  assign cmd     = {csn, rasn, casn, wen};
  assign idx     = {ba, open_row[ba][1:0], a[4:0]};
  assign flat    = {ba, open_row[ba], a[8:0]};
  assign wr_word = mem[wr_idx];
  assign dq      = rd_oe ? rd_data : 16'hzzzz;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bank_open <= '0;
      wr_evt    <= 1'b0;
      proto_err <= 1'b0;
      rd_pend   <= 1'b0;
      rd_oe     <= 1'b0;
    end else begin
      wr_evt    <= 1'b0;
      proto_err <= 1'b0;
      rd_pend   <= 1'b0;
      // cas latency 2, data on the bus one cycle after this stage
      rd_oe     <= rd_pend;
      if (cke) begin
        case (cmd)
          sdram_pkg::CMD_ACTIVE: begin
            if (bank_open[ba]) proto_err <= 1'b1;
            bank_open[ba] <= 1'b1;
            open_row[ba]  <= a;
          end
          sdram_pkg::CMD_WRITE: begin
            if (!bank_open[ba]) begin
              proto_err <= 1'b1;
            end else begin
              mem[idx] <= dq;
              wr_evt   <= 1'b1;
              wr_flat  <= flat;
              wr_idx   <= idx;
            end
            if (a[10]) bank_open[ba] <= 1'b0;
          end
          sdram_pkg::CMD_READ: begin
            if (!bank_open[ba]) proto_err <= 1'b1;
            rd_pend <= 1'b1;
            rd_data <= mem[idx] ^ ((corrupt && flat == 24'd5) ? 16'h1000 : 16'h0000);
            if (a[10]) bank_open[ba] <= 1'b0;
          end
          sdram_pkg::CMD_REFRESH: begin
            if (|bank_open) proto_err <= 1'b1;
          end
          sdram_pkg::CMD_PRECHARGE: begin
            if (a[10]) bank_open <= '0;
            else bank_open[ba] <= 1'b0;
          end
          sdram_pkg::CMD_LOAD_MODE: begin
            // burst of 1 and cas latency 2 only
            if (a[6:4] != 3'd2 || a[2:0] != 3'd0) proto_err <= 1'b1;
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

// File: tb_sdram_top.sv
`timescale 1ns/1ns

module tb_sdram_top;

  localparam int INIT_CYCLES    = 40;
  localparam int REFRESH_CYCLES = 60;
  localparam int N_WORDS        = 16;
  // seed 0 run, three random restarts, one corrupted run
  localparam int N_TESTS        = 5;
  localparam longint LIMIT_NS   =
    (longint'(N_TESTS) * 2 * N_WORDS * 20 + INIT_CYCLES + 200) * 20;

  logic        clk_design;
  logic        rst_n;
  logic [6:0]  btns;
  logic [7:0]  leds;
  logic        sdram_clk;
  logic        sdram_cke;
  logic        sdram_csn;
  logic        sdram_rasn;
  logic        sdram_casn;
  logic        sdram_wen;
  logic [1:0]  sdram_ba;
  logic [12:0] sdram_a;
  logic [1:0]  sdram_dqm;
  wire  [15:0] sdram_d;
  logic        wr_evt;
  logic [23:0] wr_flat;
  logic [15:0] wr_word;
  logic        proto_err;
  logic [5:0]  cur_seed;
  logic        test_end;
  logic [2:0]  test_id;
  logic        expect_err;
  int          pass_count;
  int          fail_count;
  int          assert_fails;

  always #10 clk_design = ~clk_design;

  sdram_top #(
    .INIT_CYCLES    (INIT_CYCLES),
    .REFRESH_CYCLES (REFRESH_CYCLES),
    .N_WORDS        (N_WORDS)
  ) i_dut (
    .clk_design (clk_design),
    .rst_n      (rst_n),
    .btns       (btns),
    .leds       (leds),
    .sdram_clk  (sdram_clk),
    .sdram_cke  (sdram_cke),
    .sdram_csn  (sdram_csn),
    .sdram_rasn (sdram_rasn),
    .sdram_casn (sdram_casn),
    .sdram_wen  (sdram_wen),
    .sdram_ba   (sdram_ba),
    .sdram_a    (sdram_a),
    .sdram_dqm  (sdram_dqm),
    .sdram_d    (sdram_d)
  );

  tb_sdram_model i_model (
    .clk       (sdram_clk),
    .rst_n     (rst_n),
    .cke       (sdram_cke),
    .csn       (sdram_csn),
    .rasn      (sdram_rasn),
    .casn      (sdram_casn),
    .wen       (sdram_wen),
    .ba        (sdram_ba),
    .a         (sdram_a),
    .dq        (sdram_d),
    .wr_evt    (wr_evt),
    .wr_flat   (wr_flat),
    .wr_word   (wr_word),
    .proto_err (proto_err)
  );

  tb_checker #(
    .N_WORDS   (N_WORDS),
    .LAST_TEST (N_TESTS - 1)
  ) i_check (
    .clk_design (clk_design),
    .rst_n      (rst_n),
    .csn        (sdram_csn),
    .rasn       (sdram_rasn),
    .casn       (sdram_casn),
    .wen        (sdram_wen),
    .a          (sdram_a),
    .dqm        (sdram_dqm),
    .leds       (leds),
    .wr_evt     (wr_evt),
    .wr_flat    (wr_flat),
    .wr_word    (wr_word),
    .proto_err  (proto_err),
    .seed       (cur_seed),
    .test_end   (test_end),
    .test_id    (test_id),
    .expect_err (expect_err),
    .pass_count (pass_count),
    .fail_count (fail_count)
  );

  // sequencer phase 2 is its finished state
  task automatic wait_run_finished();
    while (i_dut.i_seq.phase != 2'd2) @(negedge clk_design);
  endtask

  task automatic press_restart(input logic [5:0] s);
    @(negedge clk_design);
    btns     = {s, 1'b1};
    cur_seed = s;
    while (i_dut.i_seq.phase == 2'd2) @(negedge clk_design);
    btns = 7'd0;
  endtask

  task automatic close_test(input int id);
    @(negedge clk_design);
    test_id  = 3'(id);
    test_end = 1'b1;
    @(negedge clk_design);
    test_end = 1'b0;
  endtask

  // watchdog
  initial begin
    #(LIMIT_NS);
    $display("run did not finish within %0d ns", LIMIT_NS);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    void'($urandom(4));
    clk_design = 1'b0;
    rst_n      = 1'b0;
    btns       = 7'd0;
    cur_seed   = 6'd0;
    test_end   = 1'b0;
    test_id    = 3'd0;
    expect_err = 1'b0;
    repeat (3) @(posedge clk_design);
    @(negedge clk_design);
    rst_n = 1'b1;
    // first run starts from reset with seed 0
    wait_run_finished();
    close_test(0);
    for (int t = 1; t < 4; t++) begin
      press_restart(6'($urandom));
      wait_run_finished();
      close_test(t);
    end
    // damaged read of word 5 must set the sticky error led
    force i_model.corrupt = 1'b1;
    expect_err = 1'b1;
    press_restart(6'($urandom));
    wait_run_finished();
    close_test(4);
    release i_model.corrupt;
    @(negedge clk_design);
    assert_fails = i_dut.i_ctrl.i_assert.fail_cnt;
    if (assert_fails != 0) $display("controller assertions failed %0d times", assert_fails);
    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0 && assert_fails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
